/* common/cpu_bus_pkg.sv */
package cpu_bus_pkg;

	// Word and address widths of the CPU data bus
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;

	// Bytes in one data word
	localparam int WORD_BYTES = DATA_W / 8;

	// One CPU data access
	// Only one of the two flags is set for a given access
	typedef struct packed {
		logic              uncached_read;
		logic              uncached_write;
		logic [ADDR_W-1:0] address;
		logic [DATA_W-1:0] wrdata;
	} dbus_req_t;

	// Reply back to the CPU
	typedef struct packed {
		logic              stall;
		logic [DATA_W-1:0] rddata;
	} dbus_resp_t;

endpackage

/* common/axi_pkg.sv */
package axi_pkg;

	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;

	// Burst, size and length encodings
	localparam logic [1:0] BURST_INCR = 2'b01;
	localparam logic [2:0] SIZE_WORD  = 3'b010;
	localparam logic [3:0] LEN_SINGLE = 4'd0;

	// Manager side of the bus, IDs left out
	typedef struct packed {
		// AR
		logic [AXI_ADDR_W-1:0] araddr;
		logic                  arvalid;
		logic [3:0]            arlen;
		logic [2:0]            arsize;
		logic [1:0]            arburst;
		// R
		logic                  rready;
		// AW
		logic [AXI_ADDR_W-1:0] awaddr;
		logic                  awvalid;
		logic [3:0]            awlen;
		logic [2:0]            awsize;
		logic [1:0]            awburst;
		// W
		logic [AXI_DATA_W-1:0] wdata;
		logic [AXI_STRB_W-1:0] wstrb;
		logic                  wlast;
		logic                  wvalid;
		// B
		logic                  bready;
	} axi_req_t;

	// Subordinate side of the bus
	typedef struct packed {
		logic                  arready;
		logic [AXI_DATA_W-1:0] rdata;
		logic                  rvalid;
		logic                  rlast;
		logic                  awready;
		logic                  wready;
		logic                  bvalid;
		logic [1:0]            bresp;
	} axi_resp_t;

	// Uncached transfer engine states
	typedef enum logic [2:0] {
		IDLE,
		READ_ADDR,
		READ_DATA,
		WRITE_ADDR,
		WRITE_DATA,
		WRITE_RESP,
		FINISHED
	} xfer_state_t;

endpackage

/* dcache/dcache_req_stage.sv */
`timescale 1ns/1ps

module dcache_req_stage (
	input  logic                  clk,
	input  logic                  rst,
	input  cpu_bus_pkg::dbus_req_t cpu_req,
	input  logic                  stall,
	output cpu_bus_pkg::dbus_req_t pipe_req
);

	logic                           pipe_read;
	logic                           pipe_write;
	logic [cpu_bus_pkg::ADDR_W-1:0] pipe_addr;
	logic [cpu_bus_pkg::DATA_W-1:0] pipe_wdata;

	// Access flags, cleared on reset so the pipe starts idle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pipe_read  <= 1'b0;
			pipe_write <= 1'b0;
		end else if (!stall) begin
			pipe_read  <= cpu_req.uncached_read;
			pipe_write <= cpu_req.uncached_write;
		end
	end

	// Address and write data follow the same load enable
	always_ff @(posedge clk) begin
		if (!stall) begin
			pipe_addr  <= cpu_req.address;
			pipe_wdata <= cpu_req.wrdata;
		end
	end

	always_comb begin
		pipe_req.uncached_read  = pipe_read;
		pipe_req.uncached_write = pipe_write;
		pipe_req.address        = pipe_addr;
		pipe_req.wrdata         = pipe_wdata;
	end

	// A loaded access is either a load or a store, never both
	a_one_kind: assert property (
		@(posedge clk) disable iff (rst)
		!stall |=> !(pipe_req.uncached_read && pipe_req.uncached_write)
	) else $error("req_stage: read and write both set on a loaded access");

endmodule

/* dcache/dcache_uncached.sv */
`timescale 1ns/1ps

module dcache_uncached (
	input  logic                           clk,
	input  logic                           rst,
	input  cpu_bus_pkg::dbus_req_t          pipe_req,
	output logic                           stall,
	output logic [cpu_bus_pkg::DATA_W-1:0] rddata,
	output axi_pkg::axi_req_t              axi_req,
	input  axi_pkg::axi_resp_t             axi_resp
);

	axi_pkg::xfer_state_t state;
	axi_pkg::xfer_state_t state_d;

	// Last word returned on R
	logic [cpu_bus_pkg::DATA_W-1:0] load_word;

	logic ar_fire;
	logic r_fire;
	logic aw_fire;
	logic w_fire;
	logic b_fire;

	assign ar_fire = axi_req.arvalid && axi_resp.arready;
	assign r_fire  = axi_req.rready && axi_resp.rvalid;
	assign aw_fire = axi_req.awvalid && axi_resp.awready;
	assign w_fire  = axi_req.wvalid && axi_resp.wready;
	assign b_fire  = axi_req.bready && axi_resp.bvalid;

	always_comb begin
		state_d = state;
		case (state)
			axi_pkg::IDLE: begin
				if (pipe_req.uncached_read) begin
					state_d = axi_pkg::READ_ADDR;
				end else if (pipe_req.uncached_write) begin
					state_d = axi_pkg::WRITE_ADDR;
				end
			end
			axi_pkg::READ_ADDR: begin
				if (ar_fire) begin
					state_d = axi_pkg::READ_DATA;
				end
			end
			axi_pkg::READ_DATA: begin
				if (r_fire) begin
					state_d = axi_pkg::FINISHED;
				end
			end
			axi_pkg::WRITE_ADDR: begin
				if (aw_fire) begin
					state_d = axi_pkg::WRITE_DATA;
				end
			end
			axi_pkg::WRITE_DATA: begin
				if (w_fire) begin
					state_d = axi_pkg::WRITE_RESP;
				end
			end
			// Store is only done once B is back
			axi_pkg::WRITE_RESP: begin
				if (b_fire) begin
					state_d = axi_pkg::FINISHED;
				end
			end
			axi_pkg::FINISHED: begin
				state_d = axi_pkg::IDLE;
			end
			default: begin
				state_d = axi_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= axi_pkg::IDLE;
		end else begin
			state <= state_d;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			load_word <= '0;
		end else if (r_fire) begin
			load_word <= axi_resp.rdata;
		end
	end

	// Stall from the next state, so it rises the cycle after acceptance
	// and drops during FINISHED
	assign stall = (state_d != axi_pkg::IDLE);

	assign rddata = (state == axi_pkg::FINISHED || state == axi_pkg::IDLE) ? load_word : '0;

	always_comb begin
		axi_req = '0;

		// Single beat INCR of one word
		axi_req.araddr  = pipe_req.address;
		axi_req.arlen   = axi_pkg::LEN_SINGLE;
		axi_req.arsize  = axi_pkg::SIZE_WORD;
		axi_req.arburst = axi_pkg::BURST_INCR;
		axi_req.awaddr  = pipe_req.address;
		axi_req.awlen   = axi_pkg::LEN_SINGLE;
		axi_req.awsize  = axi_pkg::SIZE_WORD;
		axi_req.awburst = axi_pkg::BURST_INCR;

		axi_req.wdata = pipe_req.wrdata;
		axi_req.wstrb = {cpu_bus_pkg::WORD_BYTES{1'b1}};
		axi_req.wlast = 1'b1;

		// Valids and readies straight from the state
		axi_req.arvalid = (state == axi_pkg::READ_ADDR);
		axi_req.rready  = (state == axi_pkg::READ_DATA);
		axi_req.awvalid = (state == axi_pkg::WRITE_ADDR);
		axi_req.wvalid  = (state == axi_pkg::WRITE_DATA);
		axi_req.bready  = (state == axi_pkg::WRITE_RESP);
	end

	a_ar_stable: assert property (
		@(posedge clk) disable iff (rst)
		axi_req.arvalid && !axi_resp.arready |=> axi_req.arvalid && $stable(axi_req.araddr)
	) else $error("uncached: arvalid or araddr changed before arready");

	a_aw_stable: assert property (
		@(posedge clk) disable iff (rst)
		axi_req.awvalid && !axi_resp.awready |=> axi_req.awvalid && $stable(axi_req.awaddr)
	) else $error("uncached: awvalid or awaddr changed before awready");

	// CPU must be held while any channel is in flight
	a_stall_valid: assert property (
		@(posedge clk) disable iff (rst)
		(axi_req.arvalid || axi_req.awvalid || axi_req.wvalid) |-> stall
	) else $error("uncached: stall low with a channel valid high");

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
	input  logic                    clk,
	input  logic                    rst,
	input  cpu_bus_pkg::dbus_req_t  cpu_req,
	output cpu_bus_pkg::dbus_resp_t cpu_resp,
	output axi_pkg::axi_req_t       axi_req,
	input  axi_pkg::axi_resp_t      axi_resp
);

	cpu_bus_pkg::dbus_req_t         pipe_req;
	logic                           stall;
	logic [cpu_bus_pkg::DATA_W-1:0] rddata;

	// Holds the accepted access while the engine runs
	dcache_req_stage u_req_stage (
		.clk      (clk),
		.rst      (rst),
		.cpu_req  (cpu_req),
		.stall    (stall),
		.pipe_req (pipe_req)
	);

	dcache_uncached u_uncached (
		.clk      (clk),
		.rst      (rst),
		.pipe_req (pipe_req),
		.stall    (stall),
		.rddata   (rddata),
		.axi_req  (axi_req),
		.axi_resp (axi_resp)
	);

	assign cpu_resp.stall  = stall;
	assign cpu_resp.rddata = rddata;

endmodule

/* verification/dcache_checker.sv */
`timescale 1ns/1ps

module dcache_checker (
	input  logic                           clk,
	input  logic                           rst,
	input  cpu_bus_pkg::dbus_req_t         cpu_req,
	input  cpu_bus_pkg::dbus_resp_t        cpu_resp,
	input  axi_pkg::axi_req_t              axi_req,
	input  axi_pkg::axi_resp_t             axi_resp,
	input  logic [cpu_bus_pkg::DATA_W-1:0] exp_rddata,
	input  logic                           report,
	output int                             error_count,
	output int                             done_count
);

	// Last value stored to each address
	logic [31:0] shadow [logic [31:0]];

	cpu_bus_pkg::dbus_req_t cur;
	logic [31:0]            cur_exp;
	logic                   pending;
	logic                   started;
	logic                   have_prev;
	axi_pkg::axi_req_t      prev_req;
	axi_pkg::axi_resp_t     prev_resp;
	int ar_cnt;
	int r_cnt;
	int aw_cnt;
	int w_cnt;
	int b_cnt;
	int cur_errors;
	int pass_count;

	initial begin
		error_count = 0;
		done_count  = 0;
		pass_count  = 0;
		cur_errors  = 0;
	end

	task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("mismatch at time %0t: %s expected 0x%08h got 0x%08h", $time, name, exp, act);
			error_count++;
			cur_errors++;
		end
	endtask

	task automatic note_failure(input string what);
		$display("error at time %0t: %s", $time, what);
		error_count++;
		cur_errors++;
	endtask

	task automatic count_handshakes();
		if (axi_req.arvalid && axi_resp.arready) begin
			ar_cnt++;
			compare_word("araddr", cur.address, axi_req.araddr);
			compare_word("arlen", 32'd0, {28'd0, axi_req.arlen});
			compare_word("arsize", 32'd2, {29'd0, axi_req.arsize});
			compare_word("arburst", 32'd1, {30'd0, axi_req.arburst});
		end
		// R is only accepted after AR and before the beat
		if (axi_req.rready && (ar_cnt == 0 || r_cnt != 0))
			note_failure("rready high outside the read data phase");
		if (axi_req.rready && axi_resp.rvalid)
			r_cnt++;
		if (axi_req.awvalid && axi_resp.awready) begin
			aw_cnt++;
			compare_word("awaddr", cur.address, axi_req.awaddr);
			compare_word("awlen", 32'd0, {28'd0, axi_req.awlen});
			compare_word("awsize", 32'd2, {29'd0, axi_req.awsize});
			compare_word("awburst", 32'd1, {30'd0, axi_req.awburst});
		end
		if (axi_req.wvalid && axi_resp.wready) begin
			w_cnt++;
			compare_word("wdata", cur.wrdata, axi_req.wdata);
			compare_word("wstrb", 32'hf, {28'd0, axi_req.wstrb});
			compare_word("wlast", 32'd1, {31'd0, axi_req.wlast});
		end
		if (axi_req.bready && (w_cnt == 0 || b_cnt != 0))
			note_failure("bready high outside the write response phase");
		if (axi_req.bready && axi_resp.bvalid)
			b_cnt++;
	endtask

	// Valid and payload must hold until ready
	task automatic check_stability();
		if (prev_req.arvalid && !prev_resp.arready) begin
			if (!axi_req.arvalid || axi_req.araddr !== prev_req.araddr)
				note_failure("arvalid or araddr changed before arready");
		end
		if (prev_req.awvalid && !prev_resp.awready) begin
			if (!axi_req.awvalid || axi_req.awaddr !== prev_req.awaddr)
				note_failure("awvalid or awaddr changed before awready");
		end
		if (prev_req.wvalid && !prev_resp.wready) begin
			if (!axi_req.wvalid || axi_req.wdata !== prev_req.wdata)
				note_failure("wvalid or wdata changed before wready");
		end
	endtask

	task automatic finish_access();
		if (cur.uncached_read) begin
			if (ar_cnt != 1 || r_cnt != 1 || aw_cnt != 0 || w_cnt != 0)
				note_failure("load did not make exactly one AR and one R handshake");
			compare_word("rddata", cur_exp, cpu_resp.rddata);
			if (shadow.exists(cur.address))
				compare_word("rddata vs shadow memory", shadow[cur.address], cpu_resp.rddata);
			else
				note_failure("load from an address that was never stored");
		end else begin
			if (aw_cnt != 1 || w_cnt != 1 || b_cnt != 1 || ar_cnt != 0)
				note_failure("store released the stall without one AW, W and B handshake");
			shadow[cur.address] = cur.wrdata;
		end
		done_count++;
		if (cur_errors == 0) begin
			pass_count++;
			$display("access %0d %s at 0x%08h: ok", done_count,
				cur.uncached_read ? "load" : "store", cur.address);
		end else begin
			$display("access %0d %s at 0x%08h: failed with %0d errors", done_count,
				cur.uncached_read ? "load" : "store", cur.address, cur_errors);
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			pending   = 1'b0;
			started   = 1'b0;
			have_prev = 1'b0;
		end else begin
			// Quiet bus before the first access
			if (!started && (cpu_resp.stall || axi_req.arvalid || axi_req.awvalid ||
					axi_req.wvalid || axi_req.rready || axi_req.bready))
				note_failure("stall, an AXI valid or an AXI ready high before the first access");
			if (pending)
				count_handshakes();
			else if ((axi_req.arvalid && axi_resp.arready) || (axi_req.awvalid && axi_resp.awready))
				note_failure("AXI address handshake with no access in progress");
			if (have_prev)
				check_stability();
			if (pending && !cpu_resp.stall)
				finish_access();
			if (!cpu_resp.stall && (cpu_req.uncached_read || cpu_req.uncached_write)) begin
				cur        = cpu_req;
				cur_exp    = exp_rddata;
				pending    = 1'b1;
				started    = 1'b1;
				ar_cnt     = 0;
				r_cnt      = 0;
				aw_cnt     = 0;
				w_cnt      = 0;
				b_cnt      = 0;
				cur_errors = 0;
			end else if (pending && !cpu_resp.stall) begin
				pending = 1'b0;
			end
			prev_req  = axi_req;
			prev_resp = axi_resp;
			have_prev = 1'b1;
		end
	end

	always @(posedge report) begin
		$display("summary: %0d accesses checked, %0d passed, %0d errors",
			done_count, pass_count, error_count);
	end

endmodule

/* verification/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;

	logic                    clk;
	logic                    rst;
	cpu_bus_pkg::dbus_req_t  cpu_req;
	cpu_bus_pkg::dbus_resp_t cpu_resp;
	axi_pkg::axi_req_t       axi_req;
	axi_pkg::axi_resp_t      axi_resp;
	logic [31:0]             exp_rddata;
	logic                    report;
	logic                    loaded;
	int                      error_count;
	int                      done_count;
	int                      tb_errors;
	int                      n_lines;
	int                      n_access;
	integer                  seed = 32'h9ad3ef0e;

	// One entry per stimulus line
	logic [7:0]  kind_q [$];
	logic [31:0] addr_q [$];
	logic [31:0] wdata_q [$];
	logic [31:0] rdata_q [$];

	// Slave word memory
	logic [31:0] mem [logic [31:0]];

	dcache_top u_dut (
		.clk      (clk),
		.rst      (rst),
		.cpu_req  (cpu_req),
		.cpu_resp (cpu_resp),
		.axi_req  (axi_req),
		.axi_resp (axi_resp)
	);

	dcache_checker u_checker (
		.clk         (clk),
		.rst         (rst),
		.cpu_req     (cpu_req),
		.cpu_resp    (cpu_resp),
		.axi_req     (axi_req),
		.axi_resp    (axi_resp),
		.exp_rddata  (exp_rddata),
		.report      (report),
		.error_count (error_count),
		.done_count  (done_count)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic load_stimulus();
		int          fd;
		int          n;
		string       line;
		logic [7:0]  kind;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] rdata;
		fd = $fopen("verification/dcache_stimulus.txt", "r");
		if (fd == 0) begin
			$display("error: stimulus file verification/dcache_stimulus.txt could not be opened");
			tb_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%c %h %h %h", kind, addr, wdata, rdata);
			if (n != 4 || (kind != "R" && kind != "W" && kind != "I")) begin
				$display("error: stimulus line could not be read: %s", line);
				tb_errors++;
				continue;
			end
			kind_q.push_back(kind);
			addr_q.push_back(addr);
			wdata_q.push_back(wdata);
			rdata_q.push_back(rdata);
			if (kind != "I")
				n_access++;
		end
		$fclose(fd);
		n_lines = kind_q.size();
	endtask

	// Present one line once the bus is free
	task automatic drive_access(input int i);
		cpu_bus_pkg::dbus_req_t req;
		req.uncached_read  = (kind_q[i] == "R");
		req.uncached_write = (kind_q[i] == "W");
		req.address        = addr_q[i];
		req.wrdata         = wdata_q[i];
		@(negedge clk);
		while (cpu_resp.stall)
			@(negedge clk);
		cpu_req    = req;
		exp_rddata = rdata_q[i];
	endtask

	task automatic random_wait();
		int delay;
		delay = $unsigned($random(seed)) % 4;
		repeat (delay) @(negedge clk);
	endtask

	function automatic logic [31:0] mem_read(input logic [31:0] addr);
		if (mem.exists(addr))
			return mem[addr];
		return addr ^ 32'hc3a5_5a3c;
	endfunction

	task automatic serve_read();
		logic [31:0] addr;
		random_wait();
		axi_resp.arready = 1'b1;
		@(posedge clk);
		while (!axi_req.arvalid)
			@(posedge clk);
		addr = axi_req.araddr;
		@(negedge clk);
		axi_resp.arready = 1'b0;
		random_wait();
		axi_resp.rdata  = mem_read(addr);
		axi_resp.rvalid = 1'b1;
		axi_resp.rlast  = 1'b1;
		@(posedge clk);
		while (!axi_req.rready)
			@(posedge clk);
		@(negedge clk);
		axi_resp.rvalid = 1'b0;
		axi_resp.rlast  = 1'b0;
	endtask

	task automatic serve_write();
		logic [31:0] addr;
		random_wait();
		axi_resp.awready = 1'b1;
		@(posedge clk);
		while (!axi_req.awvalid)
			@(posedge clk);
		addr = axi_req.awaddr;
		@(negedge clk);
		axi_resp.awready = 1'b0;
		while (!axi_req.wvalid)
			@(negedge clk);
		random_wait();
		axi_resp.wready = 1'b1;
		@(posedge clk);
		while (!axi_req.wvalid)
			@(posedge clk);
		mem[addr] = axi_req.wdata;
		@(negedge clk);
		axi_resp.wready = 1'b0;
		random_wait();
		axi_resp.bvalid = 1'b1;
		axi_resp.bresp  = 2'b00;
		@(posedge clk);
		while (!axi_req.bready)
			@(posedge clk);
		@(negedge clk);
		axi_resp.bvalid = 1'b0;
	endtask

	initial begin : axi_slave
		axi_resp = '0;
		forever begin
			@(negedge clk);
			if (axi_req.arvalid)
				serve_read();
			else if (axi_req.awvalid)
				serve_write();
		end
	end

	initial begin : watchdog
		int limit;
		wait (loaded);
		limit = n_lines * 20 + 100;
		repeat (limit) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin : main_flow
		rst        = 1'b1;
		cpu_req    = '0;
		exp_rddata = '0;
		report     = 1'b0;
		loaded     = 1'b0;
		tb_errors  = 0;
		n_lines    = 0;
		n_access   = 0;
		load_stimulus();
		if (n_access == 0) begin
			$display("error: no accesses found in the stimulus file");
			tb_errors++;
		end
		loaded = 1'b1;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < n_lines; i++)
			drive_access(i);
		// Back to idle after the last access
		@(negedge clk);
		while (cpu_resp.stall)
			@(negedge clk);
		cpu_req    = '0;
		exp_rddata = '0;
		while (done_count < n_access)
			@(negedge clk);
		repeat (2) @(negedge clk);
		report = 1'b1;
		#1;
		if (tb_errors == 0 && error_count == 0 && done_count == n_access) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* verification/dcache_stimulus.txt */
# kind (W store, R load, I idle), address, write data, expected read data
# values in hex; unused columns hold 00000000
I 00000000 00000000 00000000
W 00001000 11223344 00000000
R 00001000 00000000 11223344
W 00001004 a5a5f00f 00000000
W 00001008 deadbeef 00000000
R 00001004 00000000 a5a5f00f
R 00001008 00000000 deadbeef
I 00000000 00000000 00000000
W 00002000 0badf00d 00000000
W 00001000 cafe0001 00000000
R 00001000 00000000 cafe0001
R 00002000 00000000 0badf00d
I 00000000 00000000 00000000
W 8000fffc 13579bdf 00000000
R 8000fffc 00000000 13579bdf
W 8000fffc 2468ace0 00000000
R 8000fffc 00000000 2468ace0
R 00001004 00000000 a5a5f00f
W 0000100c 00000000 00000000
R 0000100c 00000000 00000000
W 00003000 ffffffff 00000000
R 00003000 00000000 ffffffff
R 00001008 00000000 deadbeef
I 00000000 00000000 00000000

/* verilog.f */
common/cpu_bus_pkg.sv
common/axi_pkg.sv
dcache/dcache_req_stage.sv
dcache/dcache_uncached.sv
rtl/dcache_top.sv
verification/dcache_checker.sv
verification/tb_dcache.sv
